//--- cache.f
+incdir+logic
logic/lc3b_cache_pkg.sv
logic/cacheline.sv
logic/cache_datapath.sv
logic/cache_control.sv
logic/cache.sv
testbench/memory_model.sv
testbench/cache_tb.sv

//--- logic/cache.sv
`timescale 1ns/100ps
`default_nettype none

module cache (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // cpu side.
    input  wire logic                                mem_read,
    input  wire logic                                mem_write,
    input  wire lc3b_cache_pkg::lc3b_word            mem_address,
    input  wire lc3b_cache_pkg::lc3b_word            mem_wdata,
    input  wire lc3b_cache_pkg::lc3b_mem_wmask       mem_byte_enable,
    output lc3b_cache_pkg::lc3b_word                 mem_rdata,
    output logic                                     mem_resp,

    // physical memory side.
    output logic                                     pmem_read,
    output logic                                     pmem_write,
    output lc3b_cache_pkg::lc3b_word                 pmem_address,
    output lc3b_cache_pkg::lc3b_cacheline_word       pmem_wdata,
    input  wire lc3b_cache_pkg::lc3b_cacheline_word  pmem_rdata,
    input  wire logic                                pmem_resp
);

    logic cacheline_sel;
    logic tag_source_sel;
    logic load;
    logic load_all;
    logic load_lru;
    logic lru_in;
    logic hit_1;
    logic hit_any;
    logic dirty_out;
    logic lru_out;

    cache_control control (
        .clk,
        .reset,
        .mem_read,
        .mem_write,
        .hit_1,
        .hit_any,
        .dirty_out,
        .lru_out,
        .pmem_resp,
        .cacheline_sel,
        .tag_source_sel,
        .load,
        .load_all,
        .load_lru,
        .lru_in,
        .mem_resp,
        .pmem_read,
        .pmem_write
    );

    // hit_0 is only used inside the datapath for hit_any.
    cache_datapath datapath (
        .clk,
        .reset,
        .cacheline_sel,
        .tag_source_sel,
        .load,
        .load_all,
        .load_lru,
        .lru_in,
        .cpu_address (mem_address),
        .cpu_wdata   (mem_wdata),
        .byte_enable (mem_byte_enable),
        .mem_rdata   (pmem_rdata),
        .hit_0       (),
        .hit_1,
        .hit_any,
        .dirty_out,
        .lru_out,
        .cpu_rdata   (mem_rdata),
        .mem_address (pmem_address),
        .mem_wdata   (pmem_wdata)
    );

endmodule : cache

`default_nettype wire

//--- logic/cache_control.sv
`timescale 1ns/100ps
`default_nettype none

module cache_control (
    input  wire logic clk,
    input  wire logic reset,

    // cpu request levels.
    input  wire logic mem_read,
    input  wire logic mem_write,

    // status from the datapath.
    input  wire logic hit_1,
    input  wire logic hit_any,
    input  wire logic dirty_out,
    input  wire logic lru_out,

    // physical memory response.
    input  wire logic pmem_resp,

    // datapath controls.
    output logic      cacheline_sel,
    output logic      tag_source_sel,
    output logic      load,
    output logic      load_all,
    output logic      load_lru,
    output logic      lru_in,

    // handshakes.
    output logic      mem_resp,
    output logic      pmem_read,
    output logic      pmem_write
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = mem_read | mem_write;

    // ########################################
    // state register.
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ########################################
    // next state and outputs.
    // ########################################

    always_comb begin
        next_state     = state;
        cacheline_sel  = lru_out;
        tag_source_sel = 1'b1;
        load           = 1'b0;
        load_all       = 1'b0;
        load_lru       = 1'b0;
        lru_in         = lru_out;
        mem_resp       = 1'b0;
        pmem_read      = 1'b0;
        pmem_write     = 1'b0;

        case (state)
            IDLE: begin
                if (request && hit_any) begin
                    // answer in the same cycle and point lru at the other way.
                    cacheline_sel = hit_1;
                    mem_resp      = 1'b1;
                    load          = mem_write;
                    load_lru      = 1'b1;
                    lru_in        = ~hit_1;
                end else if (request) begin
                    next_state = dirty_out ? WRITEBACK : ALLOCATE;
                end
            end

            WRITEBACK: begin
                // the victim goes back to memory under its own tag.
                tag_source_sel = 1'b0;
                pmem_write     = 1'b1;
                if (pmem_resp) begin
                    next_state = ALLOCATE;
                end
            end

            ALLOCATE: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    load_all   = 1'b1;
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule : cache_control

`default_nettype wire

//--- logic/cache_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc3b_cache_cfg.svh"

module cache_datapath (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // from cache_control.
    input  wire logic                                cacheline_sel,
    input  wire logic                                tag_source_sel,
    input  wire logic                                load,
    input  wire logic                                load_all,
    input  wire logic                                load_lru,
    input  wire logic                                lru_in,

    // from the cpu.
    input  wire lc3b_cache_pkg::lc3b_word            cpu_address,
    input  wire lc3b_cache_pkg::lc3b_word            cpu_wdata,
    input  wire lc3b_cache_pkg::lc3b_mem_wmask       byte_enable,

    // from physical memory.
    input  wire lc3b_cache_pkg::lc3b_cacheline_word  mem_rdata,

    // to cache_control.
    output logic                                     hit_0,
    output logic                                     hit_1,
    output logic                                     hit_any,
    output logic                                     dirty_out,
    output logic                                     lru_out,

    // to the cpu.
    output lc3b_cache_pkg::lc3b_word                 cpu_rdata,

    // to physical memory.
    output lc3b_cache_pkg::lc3b_word                 mem_address,
    output lc3b_cache_pkg::lc3b_cacheline_word       mem_wdata
);

    lc3b_cache_pkg::lc3b_cacheline_tag     tag_in;
    lc3b_cache_pkg::lc3b_cacheline_offset  offset;

    lc3b_cache_pkg::lc3b_cacheline_tag     tag_out_0;
    lc3b_cache_pkg::lc3b_cacheline_tag     tag_out_1;
    lc3b_cache_pkg::lc3b_cacheline_tag     victim_tag;
    lc3b_cache_pkg::lc3b_cacheline_tag     addr_tag;
    lc3b_cache_pkg::lc3b_word              data_out_0;
    lc3b_cache_pkg::lc3b_word              data_out_1;
    lc3b_cache_pkg::lc3b_cacheline_word    data_all_out_0;
    lc3b_cache_pkg::lc3b_cacheline_word    data_all_out_1;
    logic                                  dirty_out_0;
    logic                                  dirty_out_1;
    logic                                  load_0;
    logic                                  load_1;
    logic                                  load_all_0;
    logic                                  load_all_1;

    // the tag is the top of the address, the word offset sits just above bit 0.
    assign tag_in = cpu_address[15 -: `LC3B_TAG_WIDTH];
    assign offset = cpu_address[`LC3B_OFFSET_WIDTH:1];

    // ########################################
    // lru bit, pointing at the way to replace.
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_out <= 1'b0;
        end else if (load_lru) begin
            lru_out <= lru_in;
        end
    end

    // ########################################
    // way selection and steering.
    // ########################################

    assign load_0     = load & ~cacheline_sel;
    assign load_1     = load & cacheline_sel;
    assign load_all_0 = load_all & ~cacheline_sel;
    assign load_all_1 = load_all & cacheline_sel;

    assign cpu_rdata  = cacheline_sel ? data_out_1 : data_out_0;
    assign mem_wdata  = cacheline_sel ? data_all_out_1 : data_all_out_0;
    assign victim_tag = cacheline_sel ? tag_out_1 : tag_out_0;

    // the dirty bit reported to control is always that of the replacement way.
    assign dirty_out  = lru_out ? dirty_out_1 : dirty_out_0;

    // writeback uses the stored tag, a fill uses the tag of the request.
    assign addr_tag    = tag_source_sel ? tag_in : victim_tag;
    assign mem_address = {addr_tag, {(16 - `LC3B_TAG_WIDTH){1'b0}}};

    assign hit_any = hit_0 | hit_1;

    // ########################################
    // the two lines.
    // ########################################

    cacheline line0 (
        .clk,
        .reset,
        .load         (load_0),
        .load_all     (load_all_0),
        .tag_in,
        .offset,
        .byte_enable,
        .data_in      (cpu_wdata),
        .data_all_in  (mem_rdata),
        .hit          (hit_0),
        .dirty_out    (dirty_out_0),
        .tag_out      (tag_out_0),
        .data_out     (data_out_0),
        .data_all_out (data_all_out_0)
    );

    cacheline line1 (
        .clk,
        .reset,
        .load         (load_1),
        .load_all     (load_all_1),
        .tag_in,
        .offset,
        .byte_enable,
        .data_in      (cpu_wdata),
        .data_all_in  (mem_rdata),
        .hit          (hit_1),
        .dirty_out    (dirty_out_1),
        .tag_out      (tag_out_1),
        .data_out     (data_out_1),
        .data_all_out (data_all_out_1)
    );

endmodule : cache_datapath

`default_nettype wire

//--- logic/cacheline.sv
`timescale 1ns/100ps
`default_nettype none

module cacheline (
    input  wire logic                                 clk,
    input  wire logic                                 reset,

    // write controls from the datapath steering.
    input  wire logic                                 load,
    input  wire logic                                 load_all,

    // address fields of the current cpu request.
    input  wire lc3b_cache_pkg::lc3b_cacheline_tag    tag_in,
    input  wire lc3b_cache_pkg::lc3b_cacheline_offset offset,

    // write data from the cpu and from memory.
    input  wire lc3b_cache_pkg::lc3b_mem_wmask        byte_enable,
    input  wire lc3b_cache_pkg::lc3b_word             data_in,
    input  wire lc3b_cache_pkg::lc3b_cacheline_word   data_all_in,

    output logic                                      hit,
    output logic                                      dirty_out,
    output lc3b_cache_pkg::lc3b_cacheline_tag         tag_out,
    output lc3b_cache_pkg::lc3b_word                  data_out,
    output lc3b_cache_pkg::lc3b_cacheline_word        data_all_out
);

    logic                                valid;
    logic                                dirty;
    lc3b_cache_pkg::lc3b_cacheline_tag   tag;
    lc3b_cache_pkg::lc3b_cacheline_word  data;

    // bit position of the addressed word inside the line.
    logic [6:0]                          word_base;
    lc3b_cache_pkg::lc3b_word            cur_word;
    lc3b_cache_pkg::lc3b_word            merged_word;

    assign word_base = {offset, 4'b0000};
    assign cur_word  = data[word_base +: 16];

    // only the enabled bytes take the new value, the rest keep the old one.
    assign merged_word = {
        byte_enable[1] ? data_in[15:8] : cur_word[15:8],
        byte_enable[0] ? data_in[7:0]  : cur_word[7:0]
    };

    // valid and dirty are the line's control state.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else if (load_all) begin
            valid <= 1'b1;
            dirty <= 1'b0;
        end else if (load) begin
            dirty <= 1'b1;
        end
    end

    // tag and data storage.
    always_ff @(posedge clk) begin
        if (load_all) begin
            tag  <= tag_in;
            data <= data_all_in;
        end else if (load) begin
            data[word_base +: 16] <= merged_word;
        end
    end

    assign hit          = valid && (tag == tag_in);
    assign dirty_out    = dirty;
    assign tag_out      = tag;
    assign data_out     = cur_word;
    assign data_all_out = data;

endmodule : cacheline

`default_nettype wire

//--- logic/lc3b_cache_cfg.svh
`ifndef LC3B_CACHE_CFG_SVH
`define LC3B_CACHE_CFG_SVH

// Geometry of the two-way unified cache.
// The tag is the upper part of the 16-bit address.
// The four low address bits select a byte within the line.

// Address bits 15 down to 4.
`define LC3B_TAG_WIDTH 12

// Address bits 3 down to 1 select one of eight words.
`define LC3B_OFFSET_WIDTH 3

// Eight 16-bit words per line.
`define LC3B_LINE_BITS 128

`endif

//--- logic/lc3b_cache_pkg.sv
`default_nettype none

`include "lc3b_cache_cfg.svh"

package lc3b_cache_pkg;

    // a cpu data word, also used for byte addresses.
    typedef logic [15:0] lc3b_word;

    // byte enable. bit 0 is the low byte and bit 1 the high byte.
    typedef logic [1:0] lc3b_mem_wmask;

    // the tag taken from address bits 15 down to 4.
    typedef logic [`LC3B_TAG_WIDTH-1:0] lc3b_cacheline_tag;

    // word select within a line, address bits 3 down to 1.
    typedef logic [`LC3B_OFFSET_WIDTH-1:0] lc3b_cacheline_offset;

    // a full line. word k sits at bits 16k+15 down to 16k.
    typedef logic [`LC3B_LINE_BITS-1:0] lc3b_cacheline_word;

endpackage : lc3b_cache_pkg

`default_nettype wire

//--- testbench/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_LATENCY  = 5;
    localparam int TEST_COUNT   = 6;
    localparam int MAX_ACCESSES = 10;
    // a dirty miss needs two memory transactions plus a few control cycles.
    localparam int WORST_MISS   = 2 * (MEM_LATENCY + 2) + 4;
    localparam int TIMEOUT_NS   = (TEST_COUNT * MAX_ACCESSES * WORST_MISS + 20) * CLK_PERIOD;

    logic                                clk;
    logic                                reset;
    logic                                mem_read;
    logic                                mem_write;
    lc3b_cache_pkg::lc3b_word            mem_address;
    lc3b_cache_pkg::lc3b_word            mem_wdata;
    lc3b_cache_pkg::lc3b_mem_wmask       mem_byte_enable;
    lc3b_cache_pkg::lc3b_word            mem_rdata;
    logic                                mem_resp;
    logic                                pmem_read;
    logic                                pmem_write;
    lc3b_cache_pkg::lc3b_word            pmem_address;
    lc3b_cache_pkg::lc3b_cacheline_word  pmem_wdata;
    lc3b_cache_pkg::lc3b_cacheline_word  pmem_rdata;
    logic                                pmem_resp;
    logic [31:0]                         read_count;
    logic [31:0]                         write_count;

    // words written by the tests are kept by their word-aligned address.
    lc3b_cache_pkg::lc3b_word            shadow [lc3b_cache_pkg::lc3b_word];
    logic [31:0]                         reads_before;
    logic [31:0]                         writes_before;

    cache DUT (.*);

    memory_model #(.LATENCY(MEM_LATENCY)) memory (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired: the cache stopped answering requests");
        $display("=== FAIL ===");
        $fatal(1, "simulation timed out");
    end

    // ########################################
    // helpers
    // ########################################

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic lc3b_cache_pkg::lc3b_word expected_word(
        input lc3b_cache_pkg::lc3b_word addr
    );
        lc3b_cache_pkg::lc3b_word key;
        key = {addr[15:1], 1'b0};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return ({addr[15:4], 4'b0000} + {12'b0, addr[3:1], 1'b0}) ^ 16'h5a5a;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    // the request is held until mem_resp, which is sampled at the falling edge.
    task automatic cpu_access(input logic write, input lc3b_cache_pkg::lc3b_word addr,
                              input lc3b_cache_pkg::lc3b_word wdata,
                              input lc3b_cache_pkg::lc3b_mem_wmask mask,
                              output lc3b_cache_pkg::lc3b_word rdata);
        @(posedge clk);
        #1;
        mem_read        = ~write;
        mem_write       = write;
        mem_address     = addr;
        mem_wdata       = wdata;
        mem_byte_enable = mask;
        do begin
            @(negedge clk);
        end while (!mem_resp);
        rdata = mem_rdata;
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic cpu_read(input string test_name, input lc3b_cache_pkg::lc3b_word addr);
        lc3b_cache_pkg::lc3b_word rdata;
        cpu_access(1'b0, addr, 16'h0000, 2'b11, rdata);
        check_value(test_name, expected_word(addr), rdata);
    endtask

    task automatic cpu_write(input lc3b_cache_pkg::lc3b_word addr,
                             input lc3b_cache_pkg::lc3b_mem_wmask mask);
        lc3b_cache_pkg::lc3b_word wdata;
        lc3b_cache_pkg::lc3b_word old_word;
        lc3b_cache_pkg::lc3b_word unused;
        wdata    = 16'($urandom());
        old_word = expected_word(addr);
        cpu_access(1'b1, addr, wdata, mask, unused);
        shadow[{addr[15:1], 1'b0}] = {mask[1] ? wdata[15:8] : old_word[15:8],
                                      mask[0] ? wdata[7:0]  : old_word[7:0]};
    endtask

    task automatic snapshot_traffic();
        reads_before  = read_count;
        writes_before = write_count;
    endtask

    task automatic check_traffic(input string test_name, input int reads, input int writes);
        check_value({test_name, " reads"}, reads, read_count - reads_before);
        check_value({test_name, " writes"}, writes, write_count - writes_before);
    endtask

    // ########################################
    // directed tests
    // ########################################

    task automatic cold_read_miss();
        snapshot_traffic();
        cpu_read("cold_read_miss", 16'h3a46);
        check_traffic("cold_read_miss", 1, 0);
    endtask

    task automatic repeat_read_hits();
        snapshot_traffic();
        for (int k = 0; k < 8; k++) begin
            cpu_read("repeat_read_hits", 16'h3a40 + 16'(2 * k));
        end
        check_traffic("repeat_read_hits", 0, 0);
    endtask

    task automatic masked_writes();
        snapshot_traffic();
        cpu_write(16'h3a42, 2'b01);
        cpu_read("masked_writes", 16'h3a42);
        cpu_write(16'h3a42, 2'b10);
        cpu_read("masked_writes", 16'h3a42);
        cpu_write(16'h3a4e, 2'b11);
        cpu_read("masked_writes", 16'h3a4e);
        check_traffic("masked_writes", 0, 0);
    endtask

    task automatic lru_replacement();
        cpu_read("lru_replacement", 16'h5002);
        cpu_read("lru_replacement", 16'h6104);
        cpu_read("lru_replacement", 16'h5002);
        cpu_read("lru_replacement", 16'h7206);
        // A was used after B, so C must have replaced B.
        snapshot_traffic();
        cpu_read("lru_replacement", 16'h5008);
        check_traffic("lru_replacement reread A", 0, 0);
        snapshot_traffic();
        cpu_read("lru_replacement", 16'h6104);
        check_traffic("lru_replacement reread B", 1, 0);
    endtask

    task automatic dirty_eviction();
        snapshot_traffic();
        cpu_write(16'h7c0a, 2'b11);
        cpu_read("dirty_eviction", 16'h8e00);
        cpu_read("dirty_eviction", 16'h9f0e);
        check_traffic("dirty_eviction evict", 3, 1);
        snapshot_traffic();
        cpu_read("dirty_eviction", 16'h7c0a);
        check_traffic("dirty_eviction refetch", 1, 0);
    endtask

    task automatic reset_clears();
        @(posedge clk);
        #1;
        mem_read    = 1'b1;
        mem_address = 16'ha00c;
        while (!pmem_read) begin
            @(negedge clk);
        end
        // the pending miss is abandoned by the reset.
        @(posedge clk);
        #1;
        mem_read = 1'b0;
        reset_dut();
        @(negedge clk);
        check_value("reset_clears outputs", 3'b000, {mem_resp, pmem_read, pmem_write});
        snapshot_traffic();
        cpu_read("reset_clears", 16'h7c0a);
        check_traffic("reset_clears", 1, 0);
    endtask

    initial begin
        void'($urandom(32'h4f2385e4));
        reset           = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = 16'h0000;
        mem_wdata       = 16'h0000;
        mem_byte_enable = 2'b00;
        reset_dut();

        cold_read_miss();
        repeat_read_hits();
        masked_writes();
        lru_replacement();
        dirty_eviction();
        reset_clears();

        $display("=== PASS ===");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

//--- testbench/memory_model.sv
`timescale 1ns/100ps
`default_nettype none

module memory_model #(
    parameter int LATENCY = 5
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                pmem_read,
    input  wire logic                                pmem_write,
    input  wire lc3b_cache_pkg::lc3b_word            pmem_address,
    input  wire lc3b_cache_pkg::lc3b_cacheline_word  pmem_wdata,
    output lc3b_cache_pkg::lc3b_cacheline_word       pmem_rdata,
    output logic                                     pmem_resp,
    output logic [31:0]                              read_count,
    output logic [31:0]                              write_count
);

    // one entry per 16-byte line, indexed by address bits 15 down to 4.
    lc3b_cache_pkg::lc3b_cacheline_word lines [0:4095];
    int unsigned                        wait_cycles;

    // word k of line address A starts out as (A + 2k) ^ 16'h5a5a.
    initial begin
        lc3b_cache_pkg::lc3b_word line_addr;
        for (int a = 0; a < 4096; a++) begin
            line_addr = 16'(a) << 4;
            for (int k = 0; k < 8; k++) begin
                lines[a][16*k +: 16] = (line_addr + 16'(2 * k)) ^ 16'h5a5a;
            end
        end
        pmem_rdata  = '0;
        pmem_resp   = 1'b0;
        wait_cycles = 0;
        read_count  = 0;
        write_count = 0;
    end

    // a request is answered after LATENCY cycles with a one-cycle response.
    always @(posedge clk) begin
        if (reset) begin
            pmem_resp   <= 1'b0;
            wait_cycles <= 0;
        end else if (pmem_resp) begin
            pmem_resp   <= 1'b0;
            wait_cycles <= 0;
        end else if (pmem_read || pmem_write) begin
            if (wait_cycles == LATENCY - 1) begin
                pmem_resp <= 1'b1;
                if (pmem_write) begin
                    lines[pmem_address[15:4]] <= pmem_wdata;
                    write_count               <= write_count + 1;
                end else begin
                    pmem_rdata <= lines[pmem_address[15:4]];
                    read_count <= read_count + 1;
                end
            end else begin
                wait_cycles <= wait_cycles + 1;
            end
        end
    end

endmodule : memory_model

`default_nettype wire
